//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it once
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module sigdecode_z_tb -o sigdecode_z_sim

output=$(./obj_dir/sigdecode_z_sim)
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

//--- sim/sigdecode_z_tb.sv
// Testbench for the z decoder with random words, edge values, stray strobes and zeroize
// Expected coefficients come from a queue of sent words and the gamma1 - z mod q rule
// Concurrent properties compare every output with the model on each clock
// Random data and valid gaps come from a fixed seed, so every run is identical

`timescale 1ns/1ps

module sigdecode_z_tb;

    // Four polynomials at up to four cycles per word plus slack for reset and idle gaps
    localparam int WATCHDOG_CYCLES = 4 * 64 * 4 + 200;
    localparam int Z_W = sigdecode_z_pkg::Z_W;
    localparam int LANES = sigdecode_z_pkg::LANES;

    logic                     clk;
    logic                     reset_n;
    logic                     zeroize_i;
    logic                     start_i;
    logic                     valid_i;
    sigdecode_z_pkg::zword_t  data_i;
    sigdecode_z_pkg::wr_req_t wr_o;
    logic                     busy_o;
    logic                     done_o;

    // The stimulus marks the words it expects the DUT to accept
    logic                                 exp_acc;
    logic [sigdecode_z_pkg::ADDR_W-1:0]   exp_idx;
    sigdecode_z_pkg::zword_t              sent_q[$];
    sigdecode_z_pkg::zword_t              popped;

    // Expected write request that trails the accepted word by one cycle
    logic                                 m_en;
    logic [sigdecode_z_pkg::ADDR_W-1:0]   m_addr;
    sigdecode_z_pkg::coeff_t [LANES-1:0]  m_c;

    // Last word of a polynomial and its delayed copies for FLUSH and DONE
    logic last_acc;
    logic last_d1;
    logic last_d2;
    logic started;

    int          errors = 0;
    int          writes_seen = 0;
    int          writes_sent = 0;
    int          done_count = 0;
    int          dones_expected = 0;
    logic [31:0] rng;

    sigdecode_z_top uut (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .start_i   (start_i),
        .valid_i   (valid_i),
        .data_i    (data_i),
        .wr_o      (wr_o),
        .busy_o    (busy_o),
        .done_o    (done_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Gamma1 - z, with q added when the difference is negative
    function automatic sigdecode_z_pkg::coeff_t ref_coeff(input logic [Z_W-1:0] z);
        int d;
        d = (1 << sigdecode_z_pkg::GAMMA1_BITS) - int'(z);
        if (d < 0) begin
            d = d + int'(sigdecode_z_pkg::DILITHIUM_Q);
        end
        return sigdecode_z_pkg::coeff_t'(d);
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        errors++;
        $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
    endtask

    task automatic flag_failure(input string what);
        errors++;
        $display("Error at %0t ns: %s", $time, what);
    endtask

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------

    assign last_acc = exp_acc && (int'(exp_idx) == sigdecode_z_pkg::N_WORDS - 1);

    always @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            m_en    <= 1'b0;
            m_addr  <= '0;
            last_d1 <= 1'b0;
            last_d2 <= 1'b0;
            started <= 1'b0;
        end else begin
            last_d1 <= last_acc;
            last_d2 <= last_d1;
            if (start_i) begin
                started <= 1'b1;
            end
            if (zeroize_i) begin
                m_en <= 1'b0;
            end else begin
                m_en <= exp_acc;
                if (exp_acc) begin
                    popped = sent_q.pop_front();
                    m_addr <= exp_idx;
                    for (int k = 0; k < LANES; k++) begin
                        m_c[k] <= ref_coeff(popped[k*Z_W +: Z_W]);
                    end
                end
            end
        end
    end

    // Outputs are stable mid cycle
    always @(negedge clk) begin
        if (wr_o.en) begin
            writes_seen++;
        end
        if (done_o) begin
            done_count++;
        end
    end

    // --------------------------------------------------
    // Assertions
    // --------------------------------------------------

    a_en: assert property (@(posedge clk) disable iff (!reset_n) wr_o.en == m_en)
        else flag_mismatch("wr_o.en", 32'($sampled(m_en)), 32'($sampled(wr_o.en)));

    a_addr: assert property (@(posedge clk) disable iff (!reset_n)
        m_en |-> wr_o.addr == m_addr)
        else flag_mismatch("wr_o.addr", 32'($sampled(m_addr)), 32'($sampled(wr_o.addr)));

    for (genvar k = 0; k < LANES; k++) begin : g_coeff
        a_c: assert property (@(posedge clk) disable iff (!reset_n)
            m_en |-> wr_o.c[k] == m_c[k])
            else flag_mismatch($sformatf("wr_o.c[%0d]", k), 32'($sampled(m_c[k])),
                               32'($sampled(wr_o.c[k])));
    end

    // Done pulses once two cycles after the last word is accepted
    a_done: assert property (@(posedge clk) disable iff (!reset_n) done_o == last_d2)
        else flag_mismatch("done_o", 32'($sampled(last_d2)), 32'($sampled(done_o)));

    a_flush: assert property (@(posedge clk) disable iff (!reset_n) last_d1 |-> busy_o)
        else flag_failure("busy_o was low while the last write was on the bus");

    a_drop: assert property (@(posedge clk) disable iff (!reset_n) last_d2 |-> !busy_o)
        else flag_failure("busy_o stayed high in the done cycle");

    a_start: assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        (start_i && !busy_o) |=> busy_o)
        else flag_failure("busy_o did not rise after a start in idle");

    a_rise: assert property (@(posedge clk) disable iff (!reset_n)
        $rose(busy_o) |-> $past(start_i))
        else flag_failure("busy_o rose without a start");

    a_fall: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(busy_o) |-> (done_o || $past(zeroize_i)))
        else flag_failure("busy_o fell with neither done nor zeroize");

    a_zero: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize_i |=> (!busy_o && !wr_o.en && wr_o.c == '0))
        else flag_failure("zeroize left busy_o, wr_o.en or a coefficient set");

    a_idle: assert property (@(posedge clk) disable iff (!reset_n)
        !started |-> (!busy_o && !done_o && !wr_o.en))
        else flag_failure("DUT was active before the first start");

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic make_word(output sigdecode_z_pkg::zword_t w);
        for (int k = 0; k < LANES; k++) begin
            rng = xorshift(rng);
            w[k*Z_W +: Z_W] = rng[Z_W-1:0];
        end
    endtask

    task automatic pulse_start();
        start_i = 1'b1;
        tick();
        start_i = 1'b0;
    endtask

    // One accepted word followed by a random gap of zero to two idle cycles
    task automatic send_word(input sigdecode_z_pkg::zword_t w, input int idx);
        int gap;
        valid_i = 1'b1;
        data_i  = w;
        exp_acc = 1'b1;
        exp_idx = idx[sigdecode_z_pkg::ADDR_W-1:0];
        sent_q.push_back(w);
        writes_sent++;
        tick();
        valid_i = 1'b0;
        exp_acc = 1'b0;
        rng = xorshift(rng);
        gap = int'(rng % 32'd3);
        repeat (gap) tick();
    endtask

    // A strobe while the DUT is not running must not produce a write
    task automatic stray_valid();
        sigdecode_z_pkg::zword_t w;
        make_word(w);
        valid_i = 1'b1;
        data_i  = w;
        tick();
        valid_i = 1'b0;
    endtask

    task automatic run_poly(input int n_words, input bit edge_first, input int stray_at);
        sigdecode_z_pkg::zword_t w;
        pulse_start();
        for (int i = 0; i < n_words; i++) begin
            make_word(w);
            if (edge_first && i == 0) begin
                // Lanes 0 to 3 hold z = 0, 2^19, 2^19 + 1 and 2^20 - 1
                w = {20'hFFFFF, 20'h80001, 20'h80000, 20'h00000};
            end
            if (i == stray_at) begin
                pulse_start();
            end
            send_word(w, i);
        end
    endtask

    task automatic wait_done();
        int cnt;
        cnt = 0;
        dones_expected++;
        while (done_count < dones_expected && cnt < 10) begin
            tick();
            cnt++;
        end
        if (done_count < dones_expected) begin
            flag_failure("done_o did not pulse after the last word");
        end
    endtask

    initial begin
        reset_n   = 1'b0;
        zeroize_i = 1'b0;
        start_i   = 1'b0;
        valid_i   = 1'b0;
        data_i    = '0;
        exp_acc   = 1'b0;
        exp_idx   = '0;
        rng       = 32'd11254;
        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;
        tick();
        stray_valid();
        tick();
        // Edge values come first and a start in the middle must be ignored
        run_poly(64, 1'b1, 20);
        wait_done();
        stray_valid();
        // Half a polynomial is cut short by zeroize
        run_poly(32, 1'b0, -1);
        zeroize_i = 1'b1;
        tick();
        zeroize_i = 1'b0;
        repeat (2) tick();
        run_poly(64, 1'b0, -1);
        wait_done();
        run_poly(64, 1'b0, -1);
        wait_done();
        repeat (4) tick();
        if (writes_seen != writes_sent) begin
            flag_mismatch("write count", 32'(writes_sent), 32'(writes_seen));
        end
        $display("Checked %0d writes and %0d done pulses, %0d errors",
                 writes_seen, done_count, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        flag_failure("watchdog expired before the tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- src/sigdecode_z_addr_ctr.sv
// Word counter and write strobe for one polynomial
// Enable and address are registered to line up with the one cycle lane latency
// The count wraps after the last word, a new start clears it anyway

`timescale 1ns/1ps

module sigdecode_z_addr_ctr (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  logic                                   zeroize_i,
    input  logic                                   clear_i,
    input  logic                                   inc_i,
    output logic                                   last_o,
    output logic                                   wr_en_o,
    output logic [sigdecode_z_pkg::ADDR_W-1:0]     wr_addr_o
);

    localparam int AW = sigdecode_z_pkg::ADDR_W;

    // Number of words accepted so far in this polynomial
    logic [AW-1:0] count_q;

    // --------------------------------------------------
    // Word count
    // --------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            count_q <= '0;
        end else if (zeroize_i || clear_i) begin
            count_q <= '0;
        end else if (inc_i) begin
            count_q <= count_q + 1'b1;
        end
    end

    // The word being accepted now is the final one of the polynomial
    assign last_o = (count_q == AW'(sigdecode_z_pkg::N_WORDS - 1));

    // --------------------------------------------------
    // Write strobe, one cycle after acceptance
    // --------------------------------------------------

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_en_o   <= 1'b0;
            wr_addr_o <= '0;
        end else if (zeroize_i) begin
            wr_en_o   <= 1'b0;
            wr_addr_o <= '0;
        end else begin
            wr_en_o <= inc_i;
            // Address holds between writes
            if (inc_i) begin
                wr_addr_o <= count_q;
            end
        end
    end

endmodule

//--- src/sigdecode_z_ctrl.sv
// Sequencer for one polynomial, start to done
// Start is honoured in IDLE and in DONE, never while busy
// Valid strobes count only in RUN, there is no back-pressure
// Zeroize is synchronous and returns straight to IDLE

`timescale 1ns/1ps

module sigdecode_z_ctrl (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize_i,
    input  logic start_i,
    input  logic valid_i,
    input  logic last_i,
    output logic clear_o,
    output logic inc_o,
    output logic busy_o,
    output logic done_o
);

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        FLUSH = 2'd2,
        DONE  = 2'd3
    } state_t;

    state_t state_q;
    state_t state_d;

    // A start that opens a new polynomial
    logic start_ok;

    // --------------------------------------------------
    // Decoded outputs
    // --------------------------------------------------

    // DONE lasts a single cycle, so a start there is not lost
    assign start_ok = start_i && (state_q == IDLE || state_q == DONE);

    // The counter must be at zero before the first word can be sampled
    assign clear_o = start_ok;

    // Words are accepted only while the run is open
    assign inc_o = valid_i && (state_q == RUN);

    // FLUSH covers the cycle where the final write is on the bus
    assign busy_o = (state_q == RUN) || (state_q == FLUSH);

    assign done_o = (state_q == DONE);

    // --------------------------------------------------
    // Next state
    // --------------------------------------------------

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_ok) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                if (inc_o && last_i) begin
                    state_d = FLUSH;
                end
            end
            FLUSH: state_d = DONE;
            DONE: state_d = start_ok ? RUN : IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= IDLE;
        end else if (zeroize_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- src/sigdecode_z_pkg.sv
// Shared constants and types for the z decoder of an ML-DSA signature
// Only the gamma1 = 2^19 parameter set is covered (ML-DSA-65 and ML-DSA-87)
// Four packed coefficients travel per input word, so one polynomial is 64 words
// Decoded coefficients are plain values in 0 to q-1, not Montgomery form

package sigdecode_z_pkg;

    // --------------------------------------------------
    // Scheme constants
    // --------------------------------------------------

    // Width of one decoded coefficient, wide enough for any value below q
    localparam int COEFF_W = 24;

    // The ML-DSA prime modulus
    localparam logic [COEFF_W-1:0] DILITHIUM_Q = 24'd8380417;

    // Gamma1 is a power of two, so the exponent is all the datapath needs
    localparam int GAMMA1_BITS = 19;

    // One packed z coefficient holds gamma1 - z in 20 bits
    localparam int Z_W = GAMMA1_BITS + 1;

    // --------------------------------------------------
    // Polynomial geometry
    // --------------------------------------------------

    // Decoding lanes, one coefficient each per word
    localparam int LANES = 4;

    localparam int N_COEFFS = 256;

    // Each word carries LANES coefficients
    localparam int N_WORDS = N_COEFFS / LANES;

    // Enough bits to index every word of one polynomial
    localparam int ADDR_W = $clog2(N_WORDS);

    // --------------------------------------------------
    // Types
    // --------------------------------------------------

    // Lane k sits in bits 20k to 20k+19, lane 0 at the bottom
    typedef logic [LANES*Z_W-1:0] zword_t;

    typedef logic [COEFF_W-1:0] coeff_t;

    // Write request towards the polynomial memory
    // Element 0 of c is lane 0 and lands in the least significant bits
    typedef struct packed {
        logic                   en;
        logic [ADDR_W-1:0]      addr;
        coeff_t [LANES-1:0]     c;
    } wr_req_t;

endpackage

//--- src/sigdecode_z_top.sv
// Decoder for the z part of an ML-DSA signature, one polynomial per start
// Each accepted word gives one write request a cycle later, no flow control
// The consumer must take every write, the source must hold off valid
// until busy is high

`timescale 1ns/1ps

module sigdecode_z_top (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        zeroize_i,
    input  logic                        start_i,
    input  logic                        valid_i,
    input  sigdecode_z_pkg::zword_t     data_i,
    output sigdecode_z_pkg::wr_req_t    wr_o,
    output logic                        busy_o,
    output logic                        done_o
);

    localparam int LANES = sigdecode_z_pkg::LANES;
    localparam int Z_W   = sigdecode_z_pkg::Z_W;

    // Control to counter
    logic clear;
    logic accept;

    // Counter back to control
    logic last;

    // Fields of the write request before they are packed
    logic                                  wr_en;
    logic [sigdecode_z_pkg::ADDR_W-1:0]    wr_addr;
    sigdecode_z_pkg::coeff_t [LANES-1:0]   lane_c;

    sigdecode_z_ctrl u_ctrl (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .start_i   (start_i),
        .valid_i   (valid_i),
        .last_i    (last),
        .clear_o   (clear),
        .inc_o     (accept),
        .busy_o    (busy_o),
        .done_o    (done_o)
    );

    sigdecode_z_addr_ctr u_addr_ctr (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .clear_i   (clear),
        .inc_i     (accept),
        .last_o    (last),
        .wr_en_o   (wr_en),
        .wr_addr_o (wr_addr)
    );

    // --------------------------------------------------
    // Decoding lanes
    // --------------------------------------------------

    // Lanes run on every cycle, the enable marks which outputs are real
    for (genvar k = 0; k < LANES; k++) begin : g_lane
        sigdecode_z_unit u_lane (
            .clk       (clk),
            .reset_n   (reset_n),
            .zeroize_i (zeroize_i),
            .data_i    (data_i[k*Z_W +: Z_W]),
            .data_o    (lane_c[k])
        );
    end

    always_comb begin
        wr_o.en   = wr_en;
        wr_o.addr = wr_addr;
        wr_o.c    = lane_c;
    end

endmodule

//--- src/sigdecode_z_unit.sv
// One decoding lane for a single packed z coefficient
// Output is gamma1 - z folded into 0 to q-1 and appears one clock after the input
// The input is treated as unsigned, so any 20-bit value is accepted
// Zeroize is synchronous and clears the pipeline register

`timescale 1ns/1ps

module sigdecode_z_unit (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  logic                                   zeroize_i,
    input  logic [sigdecode_z_pkg::Z_W-1:0]        data_i,
    output sigdecode_z_pkg::coeff_t                data_o
);

    // Gamma1 as a full width operand
    localparam sigdecode_z_pkg::coeff_t GAMMA1 =
        sigdecode_z_pkg::coeff_t'(1) << sigdecode_z_pkg::GAMMA1_BITS;

    // --------------------------------------------------
    // Stage 0 subtracts z from gamma1
    // --------------------------------------------------

    sigdecode_z_pkg::coeff_t opb;
    sigdecode_z_pkg::coeff_t diff_d;
    logic                    carry_d;

    // Registered difference and its sign
    sigdecode_z_pkg::coeff_t diff_q;
    logic                    neg_q;

    // Stage 1 candidate with q added back
    sigdecode_z_pkg::coeff_t sum;

    // Subtraction as an add of the inverted operand with a carry in
    assign opb = ~sigdecode_z_pkg::coeff_t'(data_i);

    // The carry out is set when gamma1 >= z, which means no borrow happened
    assign {carry_d, diff_d} = {1'b0, GAMMA1} + {1'b0, opb} + 25'd1;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            diff_q <= '0;
            neg_q  <= 1'b0;
        end else if (zeroize_i) begin
            diff_q <= '0;
            neg_q  <= 1'b0;
        end else begin
            diff_q <= diff_d;
            neg_q  <= ~carry_d;
        end
    end

    // --------------------------------------------------
    // Stage 1 folds a negative difference into range
    // --------------------------------------------------

    // A negative difference is at least -(2^19 - 1), so one add of q suffices
    // Wrapping at 24 bits turns the two's complement value into q - |diff|
    assign sum = diff_q + sigdecode_z_pkg::DILITHIUM_Q;

    // Non-negative results are at most 2^19 and so already below q
    assign data_o = neg_q ? sum : diff_q;

endmodule

//--- tb.f
src/sigdecode_z_pkg.sv
src/sigdecode_z_unit.sv
src/sigdecode_z_addr_ctr.sv
src/sigdecode_z_ctrl.sv
src/sigdecode_z_top.sv
sim/sigdecode_z_tb.sv
